// ==== bus_pkg.sv ====
package bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int WORD_W = DATA_W / 2;                 // one lane of the read bus
  localparam int LEN_W = 8;                           // beats minus one

  localparam logic [2:0] SIZE_4B = 3'b010;
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_WRAP = 2'b10;

  // memory model behaviour
  localparam int MEM_LATENCY = 3;                     // accept to first beat
  localparam logic [31:0] MEM_PATTERN = 32'h5a3c_96e1; // word = byte addr ^ this

endpackage

// ==== cache_pkg.sv ====
package cache_pkg;

  // line geometry, direct mapped
  localparam int OFFSET_W = 4;                        // 16-byte line
  localparam int INDEX_W = 4;
  localparam int TAG_W = 32 - OFFSET_W - INDEX_W;
  localparam int SET_N = 1 << INDEX_W;
  localparam int WORDS_PER_LINE = (1 << OFFSET_W) / 4;
  localparam int WORD_SEL_W = OFFSET_W - 2;           // word select inside a line

  // top address nibble at or above this is cached
  localparam logic [3:0] CACHEABLE_BASE = 4'h3;      // sram below stays uncached

  // response classes reported to the counters
  localparam logic [1:0] KIND_HIT = 2'd0;
  localparam logic [1:0] KIND_MISS = 2'd1;
  localparam logic [1:0] KIND_BYPASS = 2'd2;

endpackage

// ==== fetch_perf_counters.sv ====
`timescale 1ns/1ps

module fetch_perf_counters (
  input  logic        clk,
  input  logic        rstn,
  input  logic        resp_done,
  input  logic [1:0]  resp_kind,
  output logic [31:0] hit_count,
  output logic [31:0] miss_count,
  output logic [31:0] bypass_count
);

  // sticks at all ones
  function automatic logic [31:0] sat_inc(input logic [31:0] value);
    return (value == '1) ? value : value + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (!rstn) begin
      hit_count <= '0;
      miss_count <= '0;
      bypass_count <= '0;
    end else if (resp_done) begin
      case (resp_kind)
        cache_pkg::KIND_HIT:    hit_count <= sat_inc(hit_count);
        cache_pkg::KIND_MISS:   miss_count <= sat_inc(miss_count);
        cache_pkg::KIND_BYPASS: bypass_count <= sat_inc(bypass_count);
        default: ;                                   // unused code
      endcase
    end
  end

endmodule

// ==== filelist.f ====
cache_pkg.sv
bus_pkg.sv
pattern_rom.sv
fetch_perf_counters.sv
icache.sv
icache_top.sv
tb_icache_top.sv

// ==== icache.sv ====
`timescale 1ns/1ps

module icache (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           ifu_arvalid,
  input  logic [bus_pkg::ADDR_W-1:0]     ifu_araddr,
  output logic                           ifu_arready,
  output logic                           ifu_rvalid,
  output logic [bus_pkg::DATA_W-1:0]     ifu_rdata,
  input  logic                           ifu_rready,
  output logic                           mem_arvalid,
  output logic [bus_pkg::ADDR_W-1:0]     mem_araddr,
  output logic [bus_pkg::LEN_W-1:0]      mem_arlen,
  output logic [2:0]                     mem_arsize,
  output logic [1:0]                     mem_arburst,
  input  logic                           mem_arready,
  input  logic                           mem_rvalid,
  input  logic [bus_pkg::DATA_W-1:0]     mem_rdata,
  input  logic                           mem_rlast,
  output logic                           mem_rready,
  output logic                           resp_done,
  output logic [1:0]                     resp_kind
);

  logic                                valid_arr [cache_pkg::SET_N];
  logic [cache_pkg::TAG_W-1:0]         tag_arr [cache_pkg::SET_N];
  logic [bus_pkg::WORD_W-1:0]          data_arr [cache_pkg::SET_N][cache_pkg::WORDS_PER_LINE];

  logic [cache_pkg::TAG_W-1:0]         req_tag;
  logic [cache_pkg::INDEX_W-1:0]       req_index;
  logic [cache_pkg::WORD_SEL_W-1:0]    req_word;
  logic [cache_pkg::WORD_SEL_W-1:0]    first_word;
  logic                                req_cacheable;
  logic                                req_hit;
  logic                                accept;
  logic                                cacheable_sel;

  logic [cache_pkg::TAG_W-1:0]         tag_q;
  logic [cache_pkg::INDEX_W-1:0]       index_q;
  logic [cache_pkg::WORD_SEL_W-1:0]    word_q;         // running fill position
  logic [bus_pkg::WORD_W-1:0]          hit_word_q;
  logic                                ifu_arready_q;
  logic                                hit_valid_q;
  logic                                busy_q;         // miss or bypass in flight
  logic                                bypass_q;
  logic                                ar_pend_q;

  logic [bus_pkg::WORD_W-1:0]          beat_word;
  logic                                fill_fire;

  assign req_tag = ifu_araddr[bus_pkg::ADDR_W-1:cache_pkg::OFFSET_W+cache_pkg::INDEX_W];
  assign req_index = ifu_araddr[cache_pkg::OFFSET_W+cache_pkg::INDEX_W-1:cache_pkg::OFFSET_W];
  assign req_word = ifu_araddr[cache_pkg::OFFSET_W-1:2];
  assign req_cacheable = ifu_araddr[bus_pkg::ADDR_W-1 -: 4] >= cache_pkg::CACHEABLE_BASE;
  assign req_hit = req_cacheable & valid_arr[req_index] & (tag_arr[req_index] == req_tag);

  // wrap starts one word after the request so the last beat is the wanted word
  assign first_word = req_cacheable ? req_word + 1'b1 : req_word;

  assign accept = ifu_arvalid & ifu_arready;
  assign ifu_arready = ifu_arready_q;

  // address phase goes out in the acceptance cycle, held if the memory is busy
  assign cacheable_sel = accept ? req_cacheable : ~bypass_q;
  assign mem_arvalid = (accept & ~req_hit) | ar_pend_q;
  assign mem_araddr = accept ? {req_tag, req_index, first_word, 2'b00}
                             : {tag_q, index_q, word_q, 2'b00};
  assign mem_arlen = cacheable_sel ? bus_pkg::LEN_W'(cache_pkg::WORDS_PER_LINE - 1) : '0;
  assign mem_arsize = bus_pkg::SIZE_4B;
  assign mem_arburst = cacheable_sel ? bus_pkg::BURST_WRAP : bus_pkg::BURST_FIXED;

  // lane picked by address bit 2
  assign beat_word = word_q[0] ? mem_rdata[bus_pkg::DATA_W-1:bus_pkg::WORD_W]
                               : mem_rdata[bus_pkg::WORD_W-1:0];

  // final beat waits for the fetch unit
  assign mem_rready = busy_q & (~mem_rlast | ifu_rready);
  assign fill_fire = mem_rvalid & mem_rready & ~bypass_q;

  assign ifu_rvalid = hit_valid_q | (busy_q & mem_rvalid & mem_rlast);
  assign ifu_rdata = hit_valid_q ? {2{hit_word_q}} : {2{beat_word}};

  assign resp_done = ifu_rvalid & ifu_rready;
  assign resp_kind = hit_valid_q ? cache_pkg::KIND_HIT
                   : bypass_q    ? cache_pkg::KIND_BYPASS
                   :               cache_pkg::KIND_MISS;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ifu_arready_q <= 1'b1;
      hit_valid_q <= 1'b0;
      busy_q <= 1'b0;
      bypass_q <= 1'b0;
      ar_pend_q <= 1'b0;
      for (int i = 0; i < cache_pkg::SET_N; i++) begin
        valid_arr[i] <= 1'b0;
      end
    end else begin
      if (resp_done) begin
        hit_valid_q <= 1'b0;
        if (busy_q) begin
          busy_q <= 1'b0;
          ifu_arready_q <= 1'b1;   // reopens next cycle
        end
      end
      if (accept) begin
        bypass_q <= ~req_cacheable;
        if (req_hit) begin
          hit_valid_q <= 1'b1;
        end else begin
          busy_q <= 1'b1;
          ifu_arready_q <= 1'b0;
          ar_pend_q <= ~mem_arready;
        end
      end else if (ar_pend_q && mem_arready) begin
        ar_pend_q <= 1'b0;
      end
      if (fill_fire && mem_rlast) begin
        valid_arr[index_q] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      tag_q <= req_tag;
      index_q <= req_index;
      word_q <= first_word;
      hit_word_q <= data_arr[req_index][req_word];
    end else if (fill_fire) begin
      data_arr[index_q][word_q] <= beat_word;
      word_q <= word_q + 1'b1;     // wraps inside the line
      if (mem_rlast) begin
        tag_arr[index_q] <= tag_q;
      end
    end
  end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         ifu_arvalid,
  input  logic [bus_pkg::ADDR_W-1:0]   ifu_araddr,
  output logic                         ifu_arready,
  output logic                         ifu_rvalid,
  output logic [bus_pkg::DATA_W-1:0]   ifu_rdata,
  input  logic                         ifu_rready,
  output logic [31:0]                  hit_count,
  output logic [31:0]                  miss_count,
  output logic [31:0]                  bypass_count
);

  logic                          mem_arvalid;
  logic [bus_pkg::ADDR_W-1:0]    mem_araddr;
  logic [bus_pkg::LEN_W-1:0]     mem_arlen;
  logic [2:0]                    mem_arsize;
  logic [1:0]                    mem_arburst;
  logic                          mem_arready;
  logic                          mem_rvalid;
  logic [bus_pkg::DATA_W-1:0]    mem_rdata;
  logic                          mem_rlast;
  logic                          mem_rready;
  logic                          resp_done;
  logic [1:0]                    resp_kind;

  icache u_icache (
    .clk         (clk),
    .rstn        (rstn),
    .ifu_arvalid (ifu_arvalid),
    .ifu_araddr  (ifu_araddr),
    .ifu_arready (ifu_arready),
    .ifu_rvalid  (ifu_rvalid),
    .ifu_rdata   (ifu_rdata),
    .ifu_rready  (ifu_rready),
    .mem_arvalid (mem_arvalid),
    .mem_araddr  (mem_araddr),
    .mem_arlen   (mem_arlen),
    .mem_arsize  (mem_arsize),
    .mem_arburst (mem_arburst),
    .mem_arready (mem_arready),
    .mem_rvalid  (mem_rvalid),
    .mem_rdata   (mem_rdata),
    .mem_rlast   (mem_rlast),
    .mem_rready  (mem_rready),
    .resp_done   (resp_done),
    .resp_kind   (resp_kind)
  );

  pattern_rom u_pattern_rom (
    .clk     (clk),
    .rstn    (rstn),
    .arvalid (mem_arvalid),
    .araddr  (mem_araddr),
    .arlen   (mem_arlen),
    .arsize  (mem_arsize),
    .arburst (mem_arburst),
    .arready (mem_arready),
    .rvalid  (mem_rvalid),
    .rdata   (mem_rdata),
    .rlast   (mem_rlast),
    .rready  (mem_rready)
  );

  fetch_perf_counters u_perf (
    .clk          (clk),
    .rstn         (rstn),
    .resp_done    (resp_done),
    .resp_kind    (resp_kind),
    .hit_count    (hit_count),
    .miss_count   (miss_count),
    .bypass_count (bypass_count)
  );

endmodule

// ==== pattern_rom.sv ====
`timescale 1ns/1ps

module pattern_rom (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          arvalid,
  input  logic [bus_pkg::ADDR_W-1:0]    araddr,
  input  logic [bus_pkg::LEN_W-1:0]     arlen,
  input  logic [2:0]                    arsize,
  input  logic [1:0]                    arburst,
  output logic                          arready,
  output logic                          rvalid,
  output logic [bus_pkg::DATA_W-1:0]    rdata,
  output logic                          rlast,
  input  logic                          rready
);

  logic                              accept;
  logic                              arready_q;
  logic                              wait_q;          // latency countdown running
  logic                              rvalid_q;
  logic [3:0]                        cnt_q;
  logic [bus_pkg::LEN_W-1:0]         beats_left_q;
  logic [bus_pkg::ADDR_W-1:0]        addr_q;
  logic [bus_pkg::ADDR_W-1:0]        step_q;
  logic [bus_pkg::ADDR_W-1:0]        wrap_mask_q;
  logic [bus_pkg::ADDR_W-1:0]        len_ext;
  logic [bus_pkg::ADDR_W-1:0]        next_addr;
  logic [bus_pkg::WORD_W-1:0]        word;

  assign accept = arvalid & arready_q;
  assign arready = arready_q;
  assign rvalid = rvalid_q;
  assign rlast = rvalid_q & (beats_left_q == '0);

  assign len_ext = {{(bus_pkg::ADDR_W - bus_pkg::LEN_W){1'b0}}, arlen};

  // bits under the mask step and wrap, the rest stay fixed
  assign next_addr = (addr_q & ~wrap_mask_q) | ((addr_q + step_q) & wrap_mask_q);

  assign word = addr_q ^ bus_pkg::MEM_PATTERN;
  assign rdata = addr_q[2] ? {word, {bus_pkg::WORD_W{1'b0}}}
                           : {{bus_pkg::WORD_W{1'b0}}, word};

  always_ff @(posedge clk) begin
    if (!rstn) begin
      arready_q <= 1'b1;
      wait_q <= 1'b0;
      rvalid_q <= 1'b0;
      cnt_q <= '0;
      beats_left_q <= '0;
    end else if (accept) begin
      arready_q <= 1'b0;
      wait_q <= 1'b1;
      cnt_q <= 4'(bus_pkg::MEM_LATENCY - 2);  // first beat lands latency cycles out
      beats_left_q <= arlen;
    end else if (wait_q) begin
      if (cnt_q == '0) begin
        wait_q <= 1'b0;
        rvalid_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end else if (rvalid_q && rready) begin
      if (rlast) begin
        rvalid_q <= 1'b0;
        arready_q <= 1'b1;
      end else begin
        beats_left_q <= beats_left_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= araddr;
      step_q <= {{(bus_pkg::ADDR_W - 1){1'b0}}, 1'b1} << arsize;
      // incr bursts are not served, anything but wrap repeats the address
      wrap_mask_q <= (arburst == bus_pkg::BURST_WRAP) ? ((len_ext + 1'b1) << arsize) - 1'b1
                                                      : '0;
    end else if (rvalid_q && rready && !rlast) begin
      addr_q <= next_addr;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the icache testbench with Verilator, result taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
  --top-module tb_icache_top > sim.log 2>&1 \
  && ./obj_dir/Vtb_icache_top >> sim.log 2>&1 \
  || echo "SIMULATION FAILED (build or run error)" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

// ==== tb_icache_top.sv ====
`timescale 1ns/1ps

module tb_icache_top;

  localparam int WAIT_LIMIT = 200;     // cycles per wait loop
  localparam int RAND_REQS = 48;

  logic        clk;
  logic        rstn;
  logic        ifu_arvalid;
  logic [31:0] ifu_araddr;
  logic        ifu_arready;
  logic        ifu_rvalid;
  logic [63:0] ifu_rdata;
  logic        ifu_rready;
  logic [31:0] hit_count;
  logic [31:0] miss_count;
  logic [31:0] bypass_count;

  int          data_errs;
  int          timing_errs;
  int          count_errs;
  int          timeouts;
  int          exp_hits;
  int          exp_misses;
  int          exp_bypasses;
  logic [31:0] lcg_state;
  logic        shadow_valid [16];    // same geometry as the cache
  logic [23:0] shadow_tag [16];

  icache_top uut (
    .clk          (clk),
    .rstn         (rstn),
    .ifu_arvalid  (ifu_arvalid),
    .ifu_araddr   (ifu_araddr),
    .ifu_arready  (ifu_arready),
    .ifu_rvalid   (ifu_rvalid),
    .ifu_rdata    (ifu_rdata),
    .ifu_rready   (ifu_rready),
    .hit_count    (hit_count),
    .miss_count   (miss_count),
    .bypass_count (bypass_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // a stalled response keeps valid and data
  property stall_holds_response;
    @(posedge clk) disable iff (!rstn)
      (ifu_rvalid && !ifu_rready) |=> (ifu_rvalid && $stable(ifu_rdata));
  endproperty

  stall_check: assert property (stall_holds_response)
    else begin
      timing_errs++;
      $display("[ERROR] ifu_rvalid/ifu_rdata changed under stall: ifu_rvalid=%h ifu_rdata=%h",
               ifu_rvalid, ifu_rdata);
    end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'h0000, lcg_state[30:15]};
  endfunction

  // small pool of lines, indices 0..3, aliasing across tags
  function automatic logic [31:0] pick_addr(input logic [31:0] r);
    logic [23:0] tag;
    case ((r >> 8) % 5)
      0: tag = 24'h300000;
      1: tag = 24'h300001;
      2: tag = 24'h7ffff0;
      3: tag = 24'h000000;          // uncached
      default: tag = 24'h100002;    // uncached
    endcase
    return {tag, 2'b00, r[4:3], r[6:5], 2'b00};
  endfunction

  task automatic check_counters();
    assert (hit_count == 32'(exp_hits)) else begin
      count_errs++;
      $display("[ERROR] hit_count: got %h expected %h", hit_count, 32'(exp_hits));
    end
    assert (miss_count == 32'(exp_misses)) else begin
      count_errs++;
      $display("[ERROR] miss_count: got %h expected %h", miss_count, 32'(exp_misses));
    end
    assert (bypass_count == 32'(exp_bypasses)) else begin
      count_errs++;
      $display("[ERROR] bypass_count: got %h expected %h", bypass_count, 32'(exp_bypasses));
    end
  endtask

  task automatic fetch(input logic [31:0] addr);
    logic [3:0]  idx;
    logic [23:0] tag;
    logic        cacheable;
    logic        exp_hit;
    logic [31:0] exp_word;
    logic        done;
    int          wait_n;

    if (timeouts != 0) return;
    idx = addr[7:4];
    tag = addr[31:8];
    cacheable = addr[31:28] >= cache_pkg::CACHEABLE_BASE;
    exp_hit = cacheable && shadow_valid[idx] && (shadow_tag[idx] == tag);
    exp_word = {addr[31:2], 2'b00} ^ bus_pkg::MEM_PATTERN;
    ifu_arvalid <= 1'b1;
    ifu_araddr <= addr;
    done = 1'b0;
    wait_n = 0;
    while (!done && wait_n < WAIT_LIMIT) begin
      @(posedge clk);
      done = ifu_arready;             // arvalid is high, so this is acceptance
      wait_n++;
    end
    ifu_arvalid <= 1'b0;
    if (!done) begin
      timeouts++;
      $display("timeout: address %h was never accepted", addr);
      return;
    end
    done = 1'b0;
    wait_n = 0;
    while (!done && wait_n < WAIT_LIMIT) begin
      @(posedge clk);
      if (wait_n == 0 && exp_hit) begin
        assert (ifu_rvalid) else begin
          timing_errs++;
          $display("[ERROR] ifu_rvalid: got %h expected 1 one cycle after hit on %h",
                   ifu_rvalid, addr);
        end
      end
      assert (ifu_arready == exp_hit) else begin   // low only for miss or bypass
        timing_errs++;
        $display("[ERROR] ifu_arready: got %h expected %h for %h", ifu_arready, exp_hit, addr);
      end
      if (ifu_rvalid && ifu_rready) begin
        done = 1'b1;
        assert (ifu_rdata == {2{exp_word}}) else begin
          data_errs++;
          $display("[ERROR] ifu_rdata: got %h expected %h for %h", ifu_rdata, {2{exp_word}}, addr);
        end
      end
      ifu_rready <= (next_rand() % 4) != 0;       // stall about a quarter of cycles
      wait_n++;
    end
    if (!done) begin
      timeouts++;
      $display("timeout: no response for address %h", addr);
      return;
    end
    if (exp_hit) begin
      exp_hits++;
    end else if (cacheable) begin
      exp_misses++;
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx] = tag;
    end else begin
      exp_bypasses++;
    end
    @(posedge clk);
    assert (ifu_arready) else begin
      timing_errs++;
      $display("[ERROR] ifu_arready: got %h expected 1 after response for %h", ifu_arready, addr);
    end
    check_counters();
  endtask

  initial begin
    data_errs = 0;
    timing_errs = 0;
    count_errs = 0;
    timeouts = 0;
    exp_hits = 0;
    exp_misses = 0;
    exp_bypasses = 0;
    lcg_state = 32'd6;
    for (int i = 0; i < 16; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_tag[i] = '0;
    end
    rstn <= 1'b0;
    ifu_arvalid <= 1'b0;
    ifu_araddr <= '0;
    ifu_rready <= 1'b0;
    repeat (10) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);
    assert (ifu_arready === 1'b1 && ifu_rvalid === 1'b0) else begin
      timing_errs++;
      $display("[ERROR] ifu_arready/ifu_rvalid after reset: got %h/%h expected 1/0",
               ifu_arready, ifu_rvalid);
    end
    check_counters();

    // uncached reads never allocate, aliasing cached line keeps its state
    fetch(32'h0000_0040);
    fetch(32'h0000_0040);
    fetch(32'h3000_0044);
    fetch(32'h3000_0048);                 // other word of the fresh line
    fetch(32'h1000_0040);
    fetch(32'h3000_004c);
    fetch(32'h3100_0040);                 // evicts by tag
    fetch(32'h3000_0040);
    for (int i = 0; i < RAND_REQS; i++) begin
      fetch(pick_addr(next_rand()));
    end

    repeat (2) @(posedge clk);
    check_counters();
    $display("errors: data=%0d timing=%0d counters=%0d timeouts=%0d",
             data_errs, timing_errs, count_errs, timeouts);
    if (data_errs + timing_errs + count_errs + timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
